// ==== Bender.yml ====
package:
  name: keypad_calculator

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/calc_pkg.sv
      - calc/calc_controller.sv
      - verilog/add_sub_unit.sv
      - verilog/shift_add_multiplier.sv
      - verilog/keypad_calculator.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - bench/tb_keypad_calculator.sv

// ==== bench/tb_keypad_calculator.sv ====
// Strobes are spaced 24 cycles apart and operator and equal levels are held until the result
`timescale 1ns/1ps
`include "calc_defines.svh"

module tb_keypad_calculator
    import calc_pkg::*;
();

    localparam int CLK_PERIOD        = 100;
    localparam int STROBE_SPACING    = 24;
    localparam int PRESS_CYCLES      = 18;
    localparam int COMPLETE_BOUND    = 40;
    localparam int CANCEL_WATCH      = 60;
    localparam int NUM_RANDOM        = 12;
    localparam int NUM_CALCS         = NUM_RANDOM + 5;
    localparam int WORST_CALC_CYCLES = 10 * STROBE_SPACING + COMPLETE_BOUND + CANCEL_WATCH + 20;
    localparam int WATCHDOG_CYCLES   = NUM_CALCS * WORST_CALC_CYCLES + 200;

    logic                    clk;
    logic                    nRST;
    logic [`DIGIT_WIDTH-1:0] keypad_input;
    logic                    read_input;
    calc_op_t                operator_input;
    logic                    equal_input;
    logic                    complete;
    logic [`CALC_WIDTH-1:0]  display_output;

    logic [31:0]             lfsr_state;
    logic [`CALC_WIDTH-1:0]  shown;

    keypad_calculator keypad_calculator_inst (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the calculations finished");
        $display("CHECKS FAILED");
        $fatal(1, "Run exceeded its time limit");
    end

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    // Galois form, taps 32 30 26 25
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    task automatic draw_bits(input int nbits, output int value);
        int i;
        value = 0;
        for (i = 0; i < nbits; i++) begin
            value      = (value << 1) | lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #10;
    endtask

    task automatic check_quiet();
        assert (complete === 1'b0) else begin
            $display("[FAIL] complete: got 0x%0h, expected 0x0", complete);
            abort_run();
        end
        assert (display_output === shown) else begin
            $display("[FAIL] display_output: got 0x%04h, expected 0x%04h", display_output, shown);
            abort_run();
        end
    endtask

    task automatic hold_quiet(input int cycles);
        int c;
        for (c = 0; c < cycles; c++) begin
            tick();
            check_quiet();
        end
    endtask

    // One strobe plus the scale and add window, optional stray strobe while scaling
    task automatic press_digit(input int digit, input calc_op_t op, input logic eq,
                               input bit stray);
        int c;
        keypad_input   = digit[`DIGIT_WIDTH-1:0];
        operator_input = op;
        equal_input    = eq;
        read_input     = 1'b1;
        for (c = 0; c < PRESS_CYCLES; c++) begin
            tick();
            check_quiet();
            read_input = stray && (c == 7);
        end
        read_input = 1'b0;
    endtask

    task automatic wait_for_complete(input logic [`CALC_WIDTH-1:0] expected);
        int waited;
        waited = 0;
        while (complete !== 1'b1 && waited < COMPLETE_BOUND) begin
            assert (display_output === shown) else begin
                $display("[FAIL] display_output: got 0x%04h, expected 0x%04h",
                         display_output, shown);
                abort_run();
            end
            tick();
            waited++;
        end
        assert (complete === 1'b1) else begin
            $display("complete did not pulse within %0d cycles of the final digit",
                     COMPLETE_BOUND);
            abort_run();
        end
        assert (display_output === expected) else begin
            $display("[FAIL] display_output: got 0x%04h, expected 0x%04h",
                     display_output, expected);
            abort_run();
        end
        tick();
        assert (complete === 1'b0) else begin
            $display("complete stayed high for more than one cycle");
            abort_run();
        end
        assert (display_output === expected) else begin
            $display("[FAIL] display_output: got 0x%04h, expected 0x%04h",
                     display_output, expected);
            abort_run();
        end
    endtask

    // Cancel drops the operator to op_none for the second operand
    task automatic run_calc(input calc_op_t op, input int len_a, input int len_b,
                            input bit cancel, input bit stray);
        logic [`CALC_WIDTH-1:0] a;
        logic [`CALC_WIDTH-1:0] b;
        logic [`CALC_WIDTH-1:0] expected;
        calc_op_t               b_op;
        int                     d;
        int                     i;
        a    = '0;
        b    = '0;
        b_op = cancel ? op_none : op;
        for (i = 0; i < len_a; i++) begin
            draw_bits(4, d);
            d = d % 10;
            a = a * 16'd10 + d[`CALC_WIDTH-1:0];
            press_digit(d, (i == len_a - 1) ? op : op_none, 1'b0, stray && (i == 0));
            hold_quiet(STROBE_SPACING - PRESS_CYCLES);
        end
        for (i = 0; i < len_b; i++) begin
            draw_bits(4, d);
            d = d % 10;
            b = b * 16'd10 + d[`CALC_WIDTH-1:0];
            press_digit(d, b_op, (i == len_b - 1), 1'b0);
            if (i != len_b - 1) begin
                hold_quiet(STROBE_SPACING - PRESS_CYCLES);
            end
        end
        case (op)
            op_add:  expected = a + b;
            op_sub:  expected = a - b;
            default: expected = a * b;
        endcase
        if (cancel) begin
            hold_quiet(CANCEL_WATCH);
        end else begin
            wait_for_complete(expected);
            shown = expected;
        end
        operator_input = op_none;
        equal_input    = 1'b0;
    endtask

    initial begin
        int       n;
        int       v;
        int       len_a;
        int       len_b;
        calc_op_t op;
        nRST           = 1'b0;
        keypad_input   = '0;
        read_input     = 1'b0;
        operator_input = op_none;
        equal_input    = 1'b0;
        lfsr_state     = 32'd90678;
        shown          = '0;
        repeat (8) @(posedge clk);
        #10;
        nRST = 1'b1;

        hold_quiet(8);

        run_calc(op_add, 2, 3, 1'b0, 1'b0);
        // Short first operand against a long second one to force a borrow
        run_calc(op_sub, 1, 4, 1'b0, 1'b0);
        run_calc(op_mul, 5, 5, 1'b0, 1'b0);

        for (n = 0; n < NUM_RANDOM; n++) begin
            draw_bits(2, v);
            case (v % 3)
                0:       op = op_add;
                1:       op = op_sub;
                default: op = op_mul;
            endcase
            draw_bits(3, len_a);
            len_a = len_a % 5 + 1;
            draw_bits(3, len_b);
            len_b = len_b % 5 + 1;
            run_calc(op, len_a, len_b, 1'b0, 1'b0);
        end

        run_calc(op_add, 2, 2, 1'b1, 1'b0);
        run_calc(op_mul, 3, 2, 1'b0, 1'b1);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== calc/calc_controller.sv ====
// Keypad and operator inputs must hold from the read strobe until the digit has been added
`timescale 1ns/1ps
`include "calc_defines.svh"

module calc_controller
    import calc_pkg::*;
(
    input  logic                    clk,
    input  logic                    nRST,
    input  logic [`DIGIT_WIDTH-1:0] keypad_input,
    input  logic                    read_input,
    input  calc_op_t                operator_input,
    input  logic                    equal_input,
    output arith_req_t              alu_req,
    output logic                    alu_start,
    input  logic [`CALC_WIDTH-1:0]  alu_result,
    input  logic                    alu_finish,
    output arith_req_t              mul_req,
    output logic                    mul_start,
    input  logic [`CALC_WIDTH-1:0]  mul_result,
    input  logic                    mul_finish,
    output logic                    complete,
    output logic [`CALC_WIDTH-1:0]  display_output
);

    calc_state_t state, next_state;

    logic [`CALC_WIDTH-1:0] operand_a;
    logic [`CALC_WIDTH-1:0] operand_b;
    logic [`CALC_WIDTH-1:0] digit_ext;
    logic                   scale_launch;
    logic                   op_valid;
    logic                   op_is_alu;

    assign digit_ext = {{(`CALC_WIDTH - `DIGIT_WIDTH){1'b0}}, keypad_input};

    // Reads only count in the two accept states
    assign scale_launch = read_input &&
                          (state == idle_accept_first || state == accept_second);

    assign op_is_alu = (operator_input == op_add) || (operator_input == op_sub);
    assign op_valid  = op_is_alu || (operator_input == op_mul);

    always_comb begin
        next_state = state;
        case (state)
            idle_accept_first:
                if (read_input) next_state = wait_scale_first;
            wait_scale_first:
                if (mul_finish) next_state = add_digit_first;
            add_digit_first:
                next_state = (operator_input != op_none) ? accept_second : idle_accept_first;
            accept_second:
                if (read_input) next_state = wait_scale_second;
            wait_scale_second:
                if (mul_finish) next_state = add_digit_second;
            add_digit_second:
                next_state = equal_input ? issue_op : accept_second;
            issue_op:
                next_state = op_valid ? wait_op : idle_accept_first;
            wait_op: begin
                if (alu_finish) begin
                    next_state = show_sum;
                end else if (mul_finish) begin
                    next_state = show_product;
                end
            end
            show_sum, show_product:
                next_state = idle_accept_first;
            default:
                next_state = idle_accept_first;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= idle_accept_first;
            operand_a      <= '0;
            operand_b      <= '0;
            alu_start      <= 1'b0;
            mul_start      <= 1'b0;
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            state     <= next_state;
            alu_start <= (state == issue_op) && op_is_alu;
            mul_start <= scale_launch || ((state == issue_op) && (operator_input == op_mul));
            complete  <= (state == show_sum) || (state == show_product);

            case (state)
                wait_scale_first:
                    if (mul_finish) operand_a <= mul_result;
                add_digit_first:
                    operand_a <= operand_a + digit_ext;
                wait_scale_second:
                    if (mul_finish) operand_b <= mul_result;
                add_digit_second:
                    operand_b <= operand_b + digit_ext;
                issue_op: begin
                    // Bad operator abandons the calculation
                    if (!op_valid) begin
                        operand_a <= '0;
                        operand_b <= '0;
                    end
                end
                show_sum: begin
                    display_output <= alu_result;
                    operand_a      <= '0;
                    operand_b      <= '0;
                end
                show_product: begin
                    display_output <= mul_result;
                    operand_a      <= '0;
                    operand_b      <= '0;
                end
                default: ;
            endcase
        end
    end

    // Multiplier is shared between digit scaling and the multiply operation
    always_ff @(posedge clk) begin
        if (scale_launch) begin
            mul_req <= '{a: (state == accept_second) ? operand_b : operand_a,
                         b: `CALC_WIDTH'(`CALC_RADIX),
                         sub: 1'b0};
        end else if (state == issue_op) begin
            mul_req <= '{a: operand_a, b: operand_b, sub: 1'b0};
        end
        if (state == issue_op) begin
            alu_req <= '{a: operand_a, b: operand_b, sub: (operator_input == op_sub)};
        end
    end

    // Result only follows a unit finish through a show state
    a_complete_after_show: assert property (@(posedge clk) disable iff (!nRST)
        complete |-> ($past(alu_finish, 2) || $past(mul_finish, 2)));

    a_single_start: assert property (@(posedge clk) disable iff (!nRST)
        !(alu_start && mul_start));

endmodule

// ==== common/calc_defines.svh ====
// Widths and radix are fixed for a 16-bit decimal keypad and are not meant to be overridden
`ifndef CALC_DEFINES_SVH
`define CALC_DEFINES_SVH

// Operand and result width
`define CALC_WIDTH 16

// One keypad digit
`define DIGIT_WIDTH 4

// Decimal entry
`define CALC_RADIX 10

`endif

// ==== common/calc_pkg.sv ====
// Operator codes are one-hot apart from op_none and any other code is treated as invalid
`include "calc_defines.svh"

package calc_pkg;

    // Keypad operator level
    typedef enum logic [2:0] {
        op_none = 3'd0,
        op_add  = 3'd1,
        op_sub  = 3'd2,
        op_mul  = 3'd4
    } calc_op_t;

    // Controller sequencing
    typedef enum logic [3:0] {
        idle_accept_first,
        wait_scale_first,
        add_digit_first,
        accept_second,
        wait_scale_second,
        add_digit_second,
        issue_op,
        wait_op,
        show_sum,
        show_product
    } calc_state_t;

    // Request to either arithmetic unit, the multiplier ignores sub
    typedef struct packed {
        logic [`CALC_WIDTH-1:0] a;
        logic [`CALC_WIDTH-1:0] b;
        logic                   sub;
    } arith_req_t;

endpackage

// ==== sources.f ====
+incdir+common
common/calc_pkg.sv
calc/calc_controller.sv
verilog/add_sub_unit.sv
verilog/shift_add_multiplier.sv
verilog/keypad_calculator.sv
bench/tb_keypad_calculator.sv

// ==== verilog/add_sub_unit.sv ====
// Unsigned add or subtract that wraps modulo 2^16 and reports no overflow or borrow
`timescale 1ns/1ps
`include "calc_defines.svh"

module add_sub_unit
    import calc_pkg::*;
(
    input  logic                   clk,
    input  logic                   nRST,
    input  arith_req_t             req,
    input  logic                   start,
    output logic [`CALC_WIDTH-1:0] result,
    output logic                   finish
);

    logic [`CALC_WIDTH-1:0] sum;

    // Borrow wraps around on underflow
    assign sum = req.sub ? (req.a - req.b) : (req.a + req.b);

    always_ff @(posedge clk) begin
        if (start) begin
            result <= sum;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            finish <= 1'b0;
        end else begin
            finish <= start;
        end
    end

endmodule

// ==== verilog/keypad_calculator.sv ====
// Strobes outside the accept states are dropped and there is no back-pressure
`timescale 1ns/1ps
`include "calc_defines.svh"

module keypad_calculator
    import calc_pkg::*;
(
    input  logic                    clk,
    input  logic                    nRST,
    input  logic [`DIGIT_WIDTH-1:0] keypad_input,
    input  logic                    read_input,
    input  calc_op_t                operator_input,
    input  logic                    equal_input,
    output logic                    complete,
    output logic [`CALC_WIDTH-1:0]  display_output
);

    arith_req_t             alu_req;
    arith_req_t             mul_req;
    logic                   alu_start;
    logic                   alu_finish;
    logic                   mul_start;
    logic                   mul_finish;
    logic [`CALC_WIDTH-1:0] alu_result;
    logic [`CALC_WIDTH-1:0] mul_result;

    calc_controller calc_controller_inst (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .alu_req        (alu_req),
        .alu_start      (alu_start),
        .alu_result     (alu_result),
        .alu_finish     (alu_finish),
        .mul_req        (mul_req),
        .mul_start      (mul_start),
        .mul_result     (mul_result),
        .mul_finish     (mul_finish),
        .complete       (complete),
        .display_output (display_output)
    );

    add_sub_unit add_sub_unit_inst (
        .clk    (clk),
        .nRST   (nRST),
        .req    (alu_req),
        .start  (alu_start),
        .result (alu_result),
        .finish (alu_finish)
    );

    shift_add_multiplier shift_add_multiplier_inst (
        .clk    (clk),
        .nRST   (nRST),
        .req    (mul_req),
        .start  (mul_start),
        .result (mul_result),
        .finish (mul_finish)
    );

endmodule

// ==== verilog/shift_add_multiplier.sv ====
// Keeps only the low 16 product bits and a start while busy is a protocol error
`timescale 1ns/1ps
`include "calc_defines.svh"

module shift_add_multiplier
    import calc_pkg::*;
(
    input  logic                   clk,
    input  logic                   nRST,
    input  arith_req_t             req,
    input  logic                   start,
    output logic [`CALC_WIDTH-1:0] result,
    output logic                   finish
);

    localparam int STEP_W = $clog2(`CALC_WIDTH) + 1;
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(`CALC_WIDTH);

    logic [`CALC_WIDTH-1:0] mcand;
    logic [`CALC_WIDTH-1:0] mplier;
    logic [`CALC_WIDTH-1:0] acc;
    logic [STEP_W-1:0]      step;
    logic                   busy;
    logic                   done_step;

    assign done_step = busy && (step == LAST_STEP);

    // Loading counts as the first step, bit 0 of the multiplier
    always_ff @(posedge clk) begin
        if (start) begin
            acc    <= req.b[0] ? req.a : '0;
            mcand  <= req.a << 1;
            mplier <= req.b >> 1;
        end else if (busy && !done_step) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
        if (done_step) begin
            result <= acc;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy   <= 1'b0;
            step   <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                step <= STEP_W'(1);
            end else if (done_step) begin
                busy   <= 1'b0;
                finish <= 1'b1;
            end else if (busy) begin
                step <= step + 1'b1;
            end
        end
    end

    a_no_start_busy: assert property (@(posedge clk) disable iff (!nRST)
        start |-> !busy);

    a_fixed_latency: assert property (@(posedge clk) disable iff (!nRST)
        start |-> ##17 finish);

endmodule
